// ==== bench/sata_dbg_stimulus.txt ====
// tx_dword tx_k rx_dword rx_k tx_code rx_code, all hex
// K flags have byte 0 in bit 0, codes are prim_code_e values
7B4A4ABC 1 B5B5957C 1 01 02
B5B5957C 1 7B4A4ABC 1 02 01
5757B57C 1 4A4A957C 1 03 04
4A4A957C 1 5757B57C 1 04 03
3737B57C 1 D5D5B57C 1 05 06
D5D5B57C 1 3737B57C 1 06 05
9999AA7C 1 5858B57C 1 07 08
5858B57C 1 9999AA7C 1 08 07
5555B57C 1 3535B57C 1 09 0A
3535B57C 1 5555B57C 1 0A 09
5656B57C 1 D5D5AA7C 1 0B 0C
D5D5AA7C 1 5656B57C 1 0C 0B
9595AA7C 1 9595AA7C 1 0D 0D
7B4A4ABC 3 B5B5957C 8 0E 0E
5757B57C 2 3737B57C F 0E 0E
9999AA7C 4 D5D5AA7C 9 0E 0E
7B4A4ABC 0 9595AA7C 0 00 00
0000007C 1 12345678 1 0E 0E
7B4A4ABD 1 B5B5957D 1 0E 0E
12345678 0 9ABCDEF0 0 00 00
DEADBEEF 0 C0FFEE00 0 00 00
00000000 0 FFFFFFFF 0 00 00
A5A55A5A 0 0F0F0F0F 0 00 00
7B4A4ABC 1 01234567 0 01 00
89ABCDEF 0 D5D5B57C 1 00 06
9999AA7C 1 9999AA7C 1 07 07
5858B57C 1 5555B57C 2 08 0E
7B4A4ABC 1 7B4A4ABC 1 01 01
4A4A957C 1 4A4A957C 1 04 04
FFFFFFFF 0 3535B57C 1 00 0A
5656B57C 1 00000000 0 0B 00
B5B5957C 1 B5B5957C 4 02 0E

// ==== vlog.f ====
common/sata_prim_pkg.sv
common/phy_dbg_pkg.sv
verilog/reset_done_sync.sv
capture/dword_assembler.sv
capture/prim_classifier.sv
verilog/sata_dbg_top.sv
bench/tb_sata_dbg_top.sv

// ==== Bender.yml ====
package:
  name: sata_dbg

sources:
  # Packages
  - common/sata_prim_pkg.sv
  - common/phy_dbg_pkg.sv
  # Design
  - verilog/reset_done_sync.sv
  - capture/dword_assembler.sv
  - capture/prim_classifier.sv
  - verilog/sata_dbg_top.sv
  # Testbench
  - target: simulation
    files:
      - bench/tb_sata_dbg_top.sv

// ==== bench/tb_sata_dbg_top.sv ====
`timescale 1ns/1ns

module tb_sata_dbg_top;

   import phy_dbg_pkg::*;
   import sata_prim_pkg::*;

   localparam int STIM_COLS     = 6;
   localparam int STIM_MAX      = 64;
   localparam int READY_TIMEOUT = 20;
   localparam int DRAIN_TIMEOUT = 40;

   logic                 tile0_txusrclk20;
   logic                 tile0_resetdone0;
   logic [HALF_W-1:0]    tx_half;
   logic [HALF_W-1:0]    rx_half;
   logic [HALF_K_W-1:0]  tx_half_k;
   logic [HALF_K_W-1:0]  rx_half_k;
   logic                 user_ready;
   logic [DBG_W-1:0]     dbg_word;
   logic                 dbg_valid;

   // One line of the stimulus file takes STIM_COLS words
   logic [31:0]          stim_mem [0:STIM_COLS*STIM_MAX-1];
   logic [31:0]          lfsr_state;

   // Dwords still due on the debug word, with the negedge they must show up on
   logic [DWORD_W-1:0]   exp_tx_dw[$];
   logic [DWORD_W-1:0]   exp_rx_dw[$];
   logic [DWORD_K_W-1:0] exp_tx_k[$];
   logic [DWORD_K_W-1:0] exp_rx_k[$];
   prim_code_e           exp_tx_code[$];
   prim_code_e           exp_rx_code[$];
   int                   exp_cycle[$];
   int                   neg_cnt = 0;
   logic                 prev_valid = 1'b0;

   sata_dbg_top sata_dbg_top_inst
   (
      .tile0_txusrclk20_i (tile0_txusrclk20),
      .tile0_resetdone0_i (tile0_resetdone0),
      .tx_half_i          (tx_half),
      .rx_half_i          (rx_half),
      .tx_half_k_i        (tx_half_k),
      .rx_half_k_i        (rx_half_k),
      .user_ready_o       (user_ready),
      .dbg_word_o         (dbg_word),
      .dbg_valid_o        (dbg_valid)
   );

   initial tile0_txusrclk20 = 1'b0;
   always #10 tile0_txusrclk20 = ~tile0_txusrclk20;

   task automatic stop_on_failure();
      $display("Errors found");
      $fatal(1, "simulation stopped at the first failing check");
   endtask

   task automatic check_dword(input string name, input logic [DWORD_W-1:0] act,
                              input logic [DWORD_W-1:0] exp);
      if (act !== exp)
      begin
         $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, act, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_k(input string name, input logic [DWORD_K_W-1:0] act,
                          input logic [DWORD_K_W-1:0] exp);
      if (act !== exp)
      begin
         $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, act, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_code(input string name, input prim_code_e act, input prim_code_e exp);
      if (act !== exp)
      begin
         $display("ERROR at %0t ns: %s is %s (%0d), expected %s (%0d)", $time, name,
                  act.name(), act, exp.name(), exp);
         stop_on_failure();
      end
   endtask

   task automatic check_flag(input string name, input logic act, input logic exp);
      if (act !== exp)
      begin
         $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, act, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_count(input string name, input int act, input int exp);
      if (act != exp)
      begin
         $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, act, exp);
         stop_on_failure();
      end
   endtask

   // Fields are cut out at the package offsets
   task automatic check_debug_word(input logic [DWORD_W-1:0] tx_dw, input logic [DWORD_W-1:0] rx_dw,
                                   input logic [DWORD_K_W-1:0] tx_k, input logic [DWORD_K_W-1:0] rx_k,
                                   input prim_code_e tx_code, input prim_code_e rx_code);
      check_dword("dbg_word_o tx dword", dbg_word[DBG_TX_DATA_LSB +: DWORD_W], tx_dw);
      check_dword("dbg_word_o rx dword", dbg_word[DBG_RX_DATA_LSB +: DWORD_W], rx_dw);
      check_k("dbg_word_o tx k", dbg_word[DBG_TX_K_LSB +: DWORD_K_W], tx_k);
      check_k("dbg_word_o rx k", dbg_word[DBG_RX_K_LSB +: DWORD_K_W], rx_k);
      check_code("dbg_word_o tx code",
                 prim_code_e'(dbg_word[DBG_TX_CODE_LSB +: $bits(prim_code_e)]), tx_code);
      check_code("dbg_word_o rx code",
                 prim_code_e'(dbg_word[DBG_RX_CODE_LSB +: $bits(prim_code_e)]), rx_code);
   endtask

   task automatic check_idle_outputs();
      check_flag("user_ready_o", user_ready, 1'b0);
      check_flag("dbg_valid_o", dbg_valid, 1'b0);
      check_debug_word('0, '0, '0, '0, PRIM_DATA, PRIM_DATA);
   endtask

   // Called on a rising edge, the dword is due three negedges later
   task automatic push_expected(input logic [DWORD_W-1:0] tx_dw, input logic [DWORD_K_W-1:0] tx_k,
                                input logic [DWORD_W-1:0] rx_dw, input logic [DWORD_K_W-1:0] rx_k,
                                input prim_code_e tx_code, input prim_code_e rx_code);
      exp_tx_dw.push_back(tx_dw);
      exp_rx_dw.push_back(rx_dw);
      exp_tx_k.push_back(tx_k);
      exp_rx_k.push_back(rx_k);
      exp_tx_code.push_back(tx_code);
      exp_rx_code.push_back(rx_code);
      exp_cycle.push_back(neg_cnt + 3);
   endtask

   task automatic pop_expected();
      void'(exp_tx_dw.pop_front());
      void'(exp_rx_dw.pop_front());
      void'(exp_tx_k.pop_front());
      void'(exp_rx_k.pop_front());
      void'(exp_tx_code.pop_front());
      void'(exp_rx_code.pop_front());
      void'(exp_cycle.pop_front());
   endtask

   task automatic clear_expected();
      exp_tx_dw.delete();
      exp_rx_dw.delete();
      exp_tx_k.delete();
      exp_rx_k.delete();
      exp_tx_code.delete();
      exp_rx_code.delete();
      exp_cycle.delete();
   endtask

   task automatic drive_lanes(input logic [HALF_W-1:0] tx_h, input logic [HALF_K_W-1:0] tx_hk,
                              input logic [HALF_W-1:0] rx_h, input logic [HALF_K_W-1:0] rx_hk);
      tx_half   <= tx_h;
      tx_half_k <= tx_hk;
      rx_half   <= rx_h;
      rx_half_k <= rx_hk;
   endtask

   // Low half on the phase-1 cycle, high half on the phase-0 cycle after it
   task automatic send_pair(input logic [DWORD_W-1:0] tx_dw, input logic [DWORD_K_W-1:0] tx_k,
                            input logic [DWORD_W-1:0] rx_dw, input logic [DWORD_K_W-1:0] rx_k,
                            input prim_code_e tx_code, input prim_code_e rx_code);
      @(posedge tile0_txusrclk20);
      drive_lanes(tx_dw[HALF_W-1:0], tx_k[HALF_K_W-1:0], rx_dw[HALF_W-1:0], rx_k[HALF_K_W-1:0]);
      @(posedge tile0_txusrclk20);
      drive_lanes(tx_dw[DWORD_W-1:HALF_W], tx_k[DWORD_K_W-1:HALF_K_W],
                  rx_dw[DWORD_W-1:HALF_W], rx_k[DWORD_K_W-1:HALF_K_W]);
      push_expected(tx_dw, tx_k, rx_dw, rx_k, tx_code, rx_code);
   endtask

   task automatic release_and_wait_ready();
      int waited;
      waited = 0;
      @(posedge tile0_txusrclk20);
      tile0_resetdone0 <= 1'b1;
      @(negedge tile0_txusrclk20);
      while (!user_ready && waited < READY_TIMEOUT)
      begin
         waited++;
         @(negedge tile0_txusrclk20);
      end
      if (!user_ready)
      begin
         $display("user_ready_o did not rise within %0d cycles of reset release", READY_TIMEOUT);
         stop_on_failure();
      end
      check_count("user_ready_o rise latency", waited, 2);
   endtask

   // The first ready cycle already took its low half from the idle lanes
   task automatic prime_stream();
      @(posedge tile0_txusrclk20);
      drive_lanes('0, '0, '0, '0);
      push_expected('0, '0, '0, '0, PRIM_DATA, PRIM_DATA);
   endtask

   task automatic reset_mid_stream();
      @(posedge tile0_txusrclk20);
      drive_lanes(16'h4ABC, 2'b01, 16'h957C, 2'b01);
      @(posedge tile0_txusrclk20);
      // The half pair in flight is lost with the reset
      @(posedge tile0_txusrclk20);
      tile0_resetdone0 <= 1'b0;
      drive_lanes('0, '0, '0, '0);
      clear_expected();
      repeat (4)
      begin
         @(negedge tile0_txusrclk20);
         check_idle_outputs();
      end
      release_and_wait_ready();
      prime_stream();
   endtask

   task automatic drain_stream();
      int waited;
      waited = 0;
      @(posedge tile0_txusrclk20);
      drive_lanes('0, '0, '0, '0);
      while (exp_cycle.size() > 0 && waited < DRAIN_TIMEOUT)
      begin
         waited++;
         @(posedge tile0_txusrclk20);
      end
      if (exp_cycle.size() > 0)
      begin
         $display("%0d dwords never reached dbg_word_o", exp_cycle.size());
         stop_on_failure();
      end
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      logic feedback;
      feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
      return {state[30:0], feedback};
   endfunction

   task automatic draw_word(output logic [31:0] word);
      word = '0;
      for (int i = 0; i < 32; i++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         word = {word[30:0], lfsr_state[0]};
      end
   endtask

   always @(negedge tile0_txusrclk20)
   begin
      neg_cnt = neg_cnt + 1;
      if (dbg_valid && prev_valid)
      begin
         $display("dbg_valid_o was high on two consecutive cycles at %0t ns", $time);
         stop_on_failure();
      end
      if (dbg_valid)
      begin
         if (exp_cycle.size() > 0)
         begin
            check_count("dbg_valid_o cycle", neg_cnt, exp_cycle[0]);
            check_debug_word(exp_tx_dw[0], exp_rx_dw[0], exp_tx_k[0], exp_rx_k[0],
                             exp_tx_code[0], exp_rx_code[0]);
            pop_expected();
         end
         else
            // Idle lanes after the stream still give a dword every second cycle
            check_debug_word('0, '0, '0, '0, PRIM_DATA, PRIM_DATA);
      end
      else if (exp_cycle.size() > 0 && exp_cycle[0] <= neg_cnt)
      begin
         $display("dbg_valid_o missing for a dword due at %0t ns", $time);
         stop_on_failure();
      end
      prev_valid = dbg_valid;
   end

   initial
   begin
      int          line;
      int          base;
      logic [31:0] tx_rand;
      logic [31:0] rx_rand;
      tile0_resetdone0 = 1'b0;
      tx_half          = '0;
      rx_half          = '0;
      tx_half_k        = '0;
      rx_half_k        = '0;
      lfsr_state       = 32'd83706;
      $readmemh("bench/sata_dbg_stimulus.txt", stim_mem);

      repeat (16)
      begin
         @(negedge tile0_txusrclk20);
         check_idle_outputs();
      end
      release_and_wait_ready();
      prime_stream();

      line = 0;
      while (line < STIM_MAX && !$isunknown(stim_mem[line*STIM_COLS]))
      begin
         base = line * STIM_COLS;
         send_pair(stim_mem[base], stim_mem[base+1][DWORD_K_W-1:0],
                   stim_mem[base+2], stim_mem[base+3][DWORD_K_W-1:0],
                   prim_code_e'(stim_mem[base+4][7:0]), prim_code_e'(stim_mem[base+5][7:0]));
         line++;
      end
      if (line == 0)
      begin
         $display("The stimulus file held no vectors");
         stop_on_failure();
      end

      reset_mid_stream();

      // Plain data dwords, no K flags
      repeat (16)
      begin
         draw_word(tx_rand);
         draw_word(rx_rand);
         send_pair(tx_rand, 4'b0000, rx_rand, 4'b0000, PRIM_DATA, PRIM_DATA);
      end
      drain_stream();

      $display("No errors");
      $finish;
   end

endmodule

// ==== verilog/sata_dbg_top.sv ====
`timescale 1ns/1ns

module sata_dbg_top
(
   input  logic                             tile0_txusrclk20_i,
   input  logic                             tile0_resetdone0_i,
   input  logic [phy_dbg_pkg::HALF_W-1:0]   tx_half_i,
   input  logic [phy_dbg_pkg::HALF_W-1:0]   rx_half_i,
   input  logic [phy_dbg_pkg::HALF_K_W-1:0] tx_half_k_i,
   input  logic [phy_dbg_pkg::HALF_K_W-1:0] rx_half_k_i,
   output logic                             user_ready_o,
   output logic [phy_dbg_pkg::DBG_W-1:0]    dbg_word_o,
   output logic                             dbg_valid_o
);

   import phy_dbg_pkg::*;
   import sata_prim_pkg::*;

   logic [DWORD_W-1:0]   tx_asm_dword;
   logic [DWORD_W-1:0]   rx_asm_dword;
   logic [DWORD_K_W-1:0] tx_asm_k;
   logic [DWORD_K_W-1:0] rx_asm_k;
   logic                 asm_valid;

   logic [DWORD_W-1:0]   tx_dword;
   logic [DWORD_W-1:0]   rx_dword;
   logic [DWORD_K_W-1:0] tx_k;
   logic [DWORD_K_W-1:0] rx_k;
   prim_code_e           tx_code;
   prim_code_e           rx_code;

   reset_done_sync reset_done_sync_inst
   (
      .tile0_txusrclk20_i (tile0_txusrclk20_i),
      .tile0_resetdone0_i (tile0_resetdone0_i),
      .user_ready_o       (user_ready_o)
   );

   dword_assembler dword_assembler_inst
   (
      .tile0_txusrclk20_i (tile0_txusrclk20_i),
      .tile0_resetdone0_i (tile0_resetdone0_i),
      .user_ready_i       (user_ready_o),
      .tx_half_i          (tx_half_i),
      .tx_half_k_i        (tx_half_k_i),
      .rx_half_i          (rx_half_i),
      .rx_half_k_i        (rx_half_k_i),
      .tx_dword_o         (tx_asm_dword),
      .rx_dword_o         (rx_asm_dword),
      .tx_k_o             (tx_asm_k),
      .rx_k_o             (rx_asm_k),
      .dword_valid_o      (asm_valid)
   );

   prim_classifier tx_classify
   (
      .tile0_txusrclk20_i (tile0_txusrclk20_i),
      .tile0_resetdone0_i (tile0_resetdone0_i),
      .dword_i            (tx_asm_dword),
      .k_i                (tx_asm_k),
      .dword_valid_i      (asm_valid),
      .dword_o            (tx_dword),
      .k_o                (tx_k),
      .prim_code_o        (tx_code),
      .prim_valid_o       (dbg_valid_o)
   );

   // Strobe is the same as on the TX side
   prim_classifier rx_classify
   (
      .tile0_txusrclk20_i (tile0_txusrclk20_i),
      .tile0_resetdone0_i (tile0_resetdone0_i),
      .dword_i            (rx_asm_dword),
      .k_i                (rx_asm_k),
      .dword_valid_i      (asm_valid),
      .dword_o            (rx_dword),
      .k_o                (rx_k),
      .prim_code_o        (rx_code),
      .prim_valid_o       ()
   );

   // Debug word, TX and RX side by side per field
   assign dbg_word_o[DBG_TX_DATA_LSB +: DWORD_W]             = tx_dword;
   assign dbg_word_o[DBG_RX_DATA_LSB +: DWORD_W]             = rx_dword;
   assign dbg_word_o[DBG_TX_K_LSB +: DWORD_K_W]              = tx_k;
   assign dbg_word_o[DBG_RX_K_LSB +: DWORD_K_W]              = rx_k;
   assign dbg_word_o[DBG_TX_CODE_LSB +: $bits(prim_code_e)]  = tx_code;
   assign dbg_word_o[DBG_RX_CODE_LSB +: $bits(prim_code_e)]  = rx_code;

endmodule

// ==== capture/prim_classifier.sv ====
`timescale 1ns/1ns

module prim_classifier
(
   input  logic                              tile0_txusrclk20_i,
   input  logic                              tile0_resetdone0_i,
   input  logic [phy_dbg_pkg::DWORD_W-1:0]   dword_i,
   input  logic [phy_dbg_pkg::DWORD_K_W-1:0] k_i,
   input  logic                              dword_valid_i,
   output logic [phy_dbg_pkg::DWORD_W-1:0]   dword_o,
   output logic [phy_dbg_pkg::DWORD_K_W-1:0] k_o,
   output sata_prim_pkg::prim_code_e         prim_code_o,
   output logic                              prim_valid_o
);

   import sata_prim_pkg::*;

   prim_code_e code_next;

   always_comb
   begin
      code_next = PRIM_UNKNOWN;
      if (k_i == '0)
         code_next = PRIM_DATA;
      else if (k_i == PRIM_K_FLAGS)
      begin
         case (dword_i)
            PRIM_ALIGN_DW: code_next = PRIM_ALIGN;
            PRIM_SYNC_DW:  code_next = PRIM_SYNC;
            PRIM_X_RDY_DW: code_next = PRIM_X_RDY;
            PRIM_R_RDY_DW: code_next = PRIM_R_RDY;
            PRIM_SOF_DW:   code_next = PRIM_SOF;
            PRIM_EOF_DW:   code_next = PRIM_EOF;
            PRIM_CONT_DW:  code_next = PRIM_CONT;
            PRIM_WTRM_DW:  code_next = PRIM_WTRM;
            PRIM_R_IP_DW:  code_next = PRIM_R_IP;
            PRIM_R_OK_DW:  code_next = PRIM_R_OK;
            PRIM_R_ERR_DW: code_next = PRIM_R_ERR;
            PRIM_HOLD_DW:  code_next = PRIM_HOLD;
            PRIM_HOLDA_DW: code_next = PRIM_HOLDA;
            default:       code_next = PRIM_UNKNOWN;
         endcase
      end
   end

   // Result and its dword are held until the next valid dword
   always_ff @(posedge tile0_txusrclk20_i or negedge tile0_resetdone0_i)
   begin
      if (!tile0_resetdone0_i)
      begin
         dword_o      <= '0;
         k_o          <= '0;
         prim_code_o  <= PRIM_DATA;
         prim_valid_o <= 1'b0;
      end
      else
      begin
         prim_valid_o <= dword_valid_i;
         if (dword_valid_i)
         begin
            dword_o     <= dword_i;
            k_o         <= k_i;
            prim_code_o <= code_next;
         end
      end
   end

   data_iff_no_k_a : assert property (@(posedge tile0_txusrclk20_i)
      disable iff (!tile0_resetdone0_i)
      prim_valid_o |-> ((prim_code_o == PRIM_DATA) == (k_o == '0)));

endmodule

// ==== capture/dword_assembler.sv ====
`timescale 1ns/1ns

module dword_assembler
(
   input  logic                              tile0_txusrclk20_i,
   input  logic                              tile0_resetdone0_i,
   input  logic                              user_ready_i,
   input  logic [phy_dbg_pkg::HALF_W-1:0]    tx_half_i,
   input  logic [phy_dbg_pkg::HALF_K_W-1:0]  tx_half_k_i,
   input  logic [phy_dbg_pkg::HALF_W-1:0]    rx_half_i,
   input  logic [phy_dbg_pkg::HALF_K_W-1:0]  rx_half_k_i,
   output logic [phy_dbg_pkg::DWORD_W-1:0]   tx_dword_o,
   output logic [phy_dbg_pkg::DWORD_W-1:0]   rx_dword_o,
   output logic [phy_dbg_pkg::DWORD_K_W-1:0] tx_k_o,
   output logic [phy_dbg_pkg::DWORD_K_W-1:0] rx_k_o,
   output logic                              dword_valid_o
);

   import phy_dbg_pkg::*;

   logic phase_r;
   logic phase;
   logic load_hi;

   // Phase of the current cycle, 1 on the first ready cycle
   assign phase   = user_ready_i & ~phase_r;
   // Second half of the pair goes to the upper 16 bits
   assign load_hi = user_ready_i & ~phase;

   always_ff @(posedge tile0_txusrclk20_i or negedge tile0_resetdone0_i)
   begin
      if (!tile0_resetdone0_i)
      begin
         phase_r       <= 1'b0;
         dword_valid_o <= 1'b0;
      end
      else
      begin
         phase_r       <= phase;
         dword_valid_o <= load_hi;
      end
   end

   // Both lanes share the one phase
   always_ff @(posedge tile0_txusrclk20_i or negedge tile0_resetdone0_i)
   begin
      if (!tile0_resetdone0_i)
      begin
         tx_dword_o <= '0;
         rx_dword_o <= '0;
         tx_k_o     <= '0;
         rx_k_o     <= '0;
      end
      else if (phase)
      begin
         tx_dword_o[HALF_W-1:0] <= tx_half_i;
         rx_dword_o[HALF_W-1:0] <= rx_half_i;
         tx_k_o[HALF_K_W-1:0]   <= tx_half_k_i;
         rx_k_o[HALF_K_W-1:0]   <= rx_half_k_i;
      end
      else if (load_hi)
      begin
         tx_dword_o[DWORD_W-1:HALF_W]   <= tx_half_i;
         rx_dword_o[DWORD_W-1:HALF_W]   <= rx_half_i;
         tx_k_o[DWORD_K_W-1:HALF_K_W]   <= tx_half_k_i;
         rx_k_o[DWORD_K_W-1:HALF_K_W]   <= rx_half_k_i;
      end
   end

   valid_single_a : assert property (@(posedge tile0_txusrclk20_i)
      disable iff (!tile0_resetdone0_i) dword_valid_o |=> !dword_valid_o);

   // Ready only drops through reset, so a valid dword never outlives it
   valid_needs_ready_a : assert property (@(posedge tile0_txusrclk20_i)
      disable iff (!tile0_resetdone0_i) !user_ready_i |-> !dword_valid_o);

endmodule

// ==== verilog/reset_done_sync.sv ====
`timescale 1ns/1ns

module reset_done_sync
(
   input  logic tile0_txusrclk20_i,
   input  logic tile0_resetdone0_i,
   output logic user_ready_o
);

   // First stage may go metastable when reset-done releases near an edge
   logic resetdone_r;

   always_ff @(posedge tile0_txusrclk20_i or negedge tile0_resetdone0_i)
   begin
      if (!tile0_resetdone0_i)
      begin
         resetdone_r  <= 1'b0;
         user_ready_o <= 1'b0;
      end
      else
      begin
         resetdone_r  <= tile0_resetdone0_i;
         user_ready_o <= resetdone_r;
      end
   end

   // Ready only comes up once reset-done has been seen high on an earlier edge
   ready_after_done_a : assert property (@(posedge tile0_txusrclk20_i)
      $rose(user_ready_o) |-> tile0_resetdone0_i && $past(tile0_resetdone0_i));

endmodule

// ==== common/phy_dbg_pkg.sv ====
package phy_dbg_pkg;

   // Transceiver lane is 16 bits at the user clock
   localparam int HALF_W   = 16;
   localparam int HALF_K_W = 2;

   // Assembled SATA dword
   localparam int DWORD_W   = 32;
   localparam int DWORD_K_W = 4;

   // Debug word layout
   localparam int DBG_W = 88;

   localparam int DBG_TX_DATA_LSB = 0;
   localparam int DBG_RX_DATA_LSB = 32;
   localparam int DBG_TX_K_LSB    = 64;
   localparam int DBG_RX_K_LSB    = 68;
   localparam int DBG_TX_CODE_LSB = 72;
   localparam int DBG_RX_CODE_LSB = 80;

endpackage

// ==== common/sata_prim_pkg.sv ====
package sata_prim_pkg;

   // Primitive codes as shown in the debug word
   typedef enum logic [7:0]
   {
      PRIM_DATA    = 8'd0,
      PRIM_ALIGN   = 8'd1,
      PRIM_SYNC    = 8'd2,
      PRIM_X_RDY   = 8'd3,
      PRIM_R_RDY   = 8'd4,
      PRIM_SOF     = 8'd5,
      PRIM_EOF     = 8'd6,
      PRIM_CONT    = 8'd7,
      PRIM_WTRM    = 8'd8,
      PRIM_R_IP    = 8'd9,
      PRIM_R_OK    = 8'd10,
      PRIM_R_ERR   = 8'd11,
      PRIM_HOLD    = 8'd12,
      PRIM_HOLDA   = 8'd13,
      PRIM_UNKNOWN = 8'd14
   } prim_code_e;

   // Primitive dwords, byte 0 in the low bits
   localparam logic [31:0] PRIM_ALIGN_DW = 32'h7B4A_4ABC;
   localparam logic [31:0] PRIM_SYNC_DW  = 32'hB5B5_957C;
   localparam logic [31:0] PRIM_X_RDY_DW = 32'h5757_B57C;
   localparam logic [31:0] PRIM_R_RDY_DW = 32'h4A4A_957C;
   localparam logic [31:0] PRIM_SOF_DW   = 32'h3737_B57C;
   localparam logic [31:0] PRIM_EOF_DW   = 32'hD5D5_B57C;
   localparam logic [31:0] PRIM_CONT_DW  = 32'h9999_AA7C;
   localparam logic [31:0] PRIM_WTRM_DW  = 32'h5858_B57C;
   localparam logic [31:0] PRIM_R_IP_DW  = 32'h5555_B57C;
   localparam logic [31:0] PRIM_R_OK_DW  = 32'h3535_B57C;
   localparam logic [31:0] PRIM_R_ERR_DW = 32'h5656_B57C;
   localparam logic [31:0] PRIM_HOLD_DW  = 32'hD5D5_AA7C;
   localparam logic [31:0] PRIM_HOLDA_DW = 32'h9595_AA7C;

   // Every primitive starts with a K28.x in byte 0, the rest are data bytes
   localparam logic [3:0] PRIM_K_FLAGS = 4'b0001;

endpackage
